/* tb.f */
rob_cfg_pkg.sv
rob_msg_pkg.sv
rob_alloc.sv
rob_entry_table.sv
rob_retire.sv
rob_squash.sv
rob_top.sv
tb_rob.sv

/* Bender.yml */
package:
  name: rob

sources:
  - rob_cfg_pkg.sv
  - rob_msg_pkg.sv
  - rob_alloc.sv
  - rob_entry_table.sv
  - rob_retire.sv
  - rob_squash.sv
  - rob_top.sv
  - target: test
    files:
      - tb_rob.sv

/* tb_rob.sv */
//==========================================================================
// testbench for the reorder buffer top; drives dispatch, writeback and
// mispredict, checks commits against an in-order reference queue
//==========================================================================
`default_nettype none
`timescale 1ns/1ns

module tb_rob;

    // tracked instruction in dispatch order
    typedef struct packed {
        rob_cfg_pkg::rob_idx_t idx;
        logic                  done;
        rob_msg_pkg::commit_t  exp;
    } track_t;

    localparam rob_msg_pkg::wb_req_t no_wb = '0;
    // cycle budget per test: reset, 1, 2, 3, 4, 5, 6
    localparam int run_cycles = 5 + 10 + 20 + 40 + 200 + 20 + 40;

    logic                    clock;
    logic                    reset;
    logic                    dispatch_valid_i;
    rob_msg_pkg::disp_req_t  dispatch_i;
    logic                    dispatch_ready_o;
    logic                    alloc_o;
    rob_cfg_pkg::rob_idx_t   alloc_idx_o;
    rob_msg_pkg::wb_req_t    wb_i [rob_cfg_pkg::wb_ports];
    logic                    mispredict_i;
    rob_cfg_pkg::rob_idx_t   mispredict_idx_i;
    logic                    commit_valid_o;
    rob_msg_pkg::commit_t    commit_o;
    logic                    free_valid_o;
    rob_cfg_pkg::phys_mask_t free_mask_o;

    // reference state
    track_t                  exp_q [$];
    rob_cfg_pkg::rob_idx_t   exp_tail;
    rob_msg_pkg::disp_req_t  pend_req;
    logic                    pend_valid;
    logic [31:0]             rng_state;
    int                      errors;
    int                      test_err_base;
    int                      tests_run;
    int                      tests_passed;
    int                      commit_count;

    rob_top rob_top_inst (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .alloc_o          (alloc_o),
        .alloc_idx_o      (alloc_idx_o),
        .wb_i             (wb_i),
        .mispredict_i     (mispredict_i),
        .mispredict_idx_i (mispredict_idx_i),
        .commit_valid_o   (commit_valid_o),
        .commit_o         (commit_o),
        .free_valid_o     (free_valid_o),
        .free_mask_o      (free_mask_o)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // run limit, twice the summed test budgets
    initial begin
        #(run_cycles * 2 * 100);
        $display("run timed out after %0d cycles", run_cycles * 2);
        $display("TEST FAIL");
        $finish;
    end

    //======================================================================
    // helpers
    //======================================================================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // random rename result, old mapping of r0 now and then
    function automatic rob_msg_pkg::disp_req_t rand_req();
        logic [31:0]            r;
        rob_msg_pkg::disp_req_t q;
        r         = next_rand();
        q.rd_wen  = r[0];
        q.rd_arch = r[5:1];
        q.new_prf = r[11:6];
        q.old_prf = (r[14:12] == 3'd0) ? '0 : r[20:15];
        return q;
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        foreach (exp_q[i]) begin
            if (!exp_q[i].done) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("error %0t: %s", $time, msg);
        end
    endtask

    task automatic apply_inputs(input logic dv, input rob_msg_pkg::wb_req_t w0,
                                input rob_msg_pkg::wb_req_t w1, input logic mp,
                                input rob_cfg_pkg::rob_idx_t mi);
        dispatch_valid_i <= dv;
        dispatch_i       <= pend_req;
        wb_i[0]          <= w0;
        wb_i[1]          <= w1;
        mispredict_i     <= mp;
        mispredict_idx_i <= mi;
    endtask

    // drive on the rising edge, come back at the falling edge
    task automatic drive_cycle(input logic dv);
        @(posedge clock);
        apply_inputs(dv, no_wb, no_wb, 1'b0, '0);
        @(negedge clock);
    endtask

    // one attempt; the request is held until taken
    task automatic try_dispatch(output logic taken);
        track_t t;
        if (!pend_valid) begin
            pend_req   = rand_req();
            pend_valid = 1'b1;
        end
        drive_cycle(1'b1);
        taken = alloc_o;
        if (taken) begin
            check(alloc_idx_o == exp_tail,
                  $sformatf("allocation index %0d, expected %0d", alloc_idx_o, exp_tail));
            t.idx             = alloc_idx_o;
            t.done            = 1'b0;
            t.exp.rd_wen      = pend_req.rd_wen;
            t.exp.rd_arch     = pend_req.rd_arch;
            t.exp.new_prf     = pend_req.new_prf;
            t.exp.old_prf     = pend_req.old_prf;
            t.exp.value       = '0;
            exp_q.push_back(t);
            exp_tail          = exp_tail + 1'b1;
            pend_valid        = 1'b0;
        end
    endtask

    // up to two writebacks on random in-flight entries
    task automatic write_back_some(input int n);
        int                   cand [$];
        int                   pos;
        rob_msg_pkg::wb_req_t w [2];
        @(posedge clock);
        w[0] = no_wb;
        w[1] = no_wb;
        foreach (exp_q[i]) begin
            if (!exp_q[i].done) begin
                cand.push_back(i);
            end
        end
        for (int p = 0; p < n && p < 2; p++) begin
            if (cand.size() > 0) begin
                pos                          = next_rand() % cand.size();
                w[p].valid                   = 1'b1;
                w[p].rob_idx                 = exp_q[cand[pos]].idx;
                w[p].value                   = next_rand();
                exp_q[cand[pos]].done        = 1'b1;
                exp_q[cand[pos]].exp.value   = w[p].value;
                cand.delete(pos);
            end
        end
        apply_inputs(1'b0, w[0], w[1], 1'b0, '0);
        @(negedge clock);
    endtask

    // mispredict on queue position k, writeback kept going in that cycle
    task automatic squash_at(input int k, output rob_cfg_pkg::phys_mask_t exp_mask);
        rob_cfg_pkg::rob_idx_t br_idx;
        rob_msg_pkg::wb_req_t  w0;
        rob_msg_pkg::wb_req_t  w1;
        @(posedge clock);
        br_idx   = exp_q[k].idx;
        exp_mask = '0;
        w0       = no_wb;
        for (int i = k + 1; i < exp_q.size(); i++) begin
            if (exp_q[i].exp.old_prf != '0) begin
                exp_mask[exp_q[i].exp.old_prf] = 1'b1;
            end
        end
        // one port hits a squashed entry, the other the branch
        if (exp_q.size() > k + 1) begin
            w0 = '{valid: 1'b1, rob_idx: exp_q[k + 1].idx, value: next_rand()};
        end
        w1                  = '{valid: 1'b1, rob_idx: br_idx, value: next_rand()};
        exp_q[k].done       = 1'b1;
        exp_q[k].exp.value  = w1.value;
        while (exp_q.size() > k + 1) begin
            void'(exp_q.pop_back());
        end
        exp_tail = br_idx + 1'b1;
        if (!pend_valid) begin
            pend_req   = rand_req();
            pend_valid = 1'b1;
        end
        apply_inputs(1'b1, w0, w1, 1'b1, br_idx);
        @(negedge clock);
        check(!dispatch_ready_o && !alloc_o, "dispatch was accepted during a mispredict");
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < limit) begin
            drive_cycle(1'b0);
            n++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("buffer did not drain in %0d cycles, %0d left", limit, exp_q.size());
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            tests_passed++;
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    //======================================================================
    // commit monitor and protocol assertions
    //======================================================================

    always @(negedge clock) begin
        if (!reset && commit_valid_o) begin
            commit_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("error %0t: commit with no instruction in flight", $time);
            end else begin
                check(exp_q[0].done, "commit of an entry that had no writeback");
                check(commit_o == exp_q[0].exp,
                      $sformatf("commit %h, expected %h", commit_o, exp_q[0].exp));
                void'(exp_q.pop_front());
            end
        end
    end

    mp_blocks_dispatch: assert property (@(posedge clock) disable iff (reset)
        mispredict_i |-> (!dispatch_ready_o && !alloc_o)) else begin
        errors++;
        $display("error %0t: dispatch ready during mispredict", $time);
    end

    // free pulse exactly one cycle after each mispredict
    free_follows_mp: assert property (@(posedge clock) disable iff (reset)
        free_valid_o == $past(mispredict_i)) else begin
        errors++;
        $display("error %0t: free_valid_o %b out of step", $time, free_valid_o);
    end

    //======================================================================
    // test sequence
    //======================================================================

    initial begin
        logic                    taken;
        int                      k;
        int                      base;
        rob_cfg_pkg::rob_idx_t   br_idx;
        rob_cfg_pkg::phys_mask_t exp_mask;

        reset            = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_i       = '0;
        wb_i[0]          = no_wb;
        wb_i[1]          = no_wb;
        mispredict_i     = 1'b0;
        mispredict_idx_i = '0;
        pend_req         = '0;
        pend_valid       = 1'b0;
        exp_tail         = '0;
        rng_state        = 32'he19b_1a60;
        errors           = 0;
        test_err_base    = 0;
        tests_run        = 0;
        tests_passed     = 0;
        commit_count     = 0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // quiet outputs after reset, first slot is 0
        repeat (3) begin
            drive_cycle(1'b0);
            check(!commit_valid_o && !free_valid_o && dispatch_ready_o, "bad state after reset");
        end
        try_dispatch(taken);
        check(taken && exp_q[0].idx == '0, "first allocation did not get index 0");
        end_test("reset and first allocation");

        // fill to rob_depth, then the extra request must wait
        for (int i = 1; i < rob_cfg_pkg::rob_depth; i++) begin
            try_dispatch(taken);
            check(taken, "dispatch refused before the buffer was full");
        end
        try_dispatch(taken);
        check(!taken && !dispatch_ready_o, "full buffer still accepted dispatch");
        end_test("fill to full");

        // out of order writeback, in order commit
        while (count_pending() > 0) begin
            write_back_some(2);
        end
        wait_drain(20);
        end_test("random writeback order");

        // stream past two wraps of the index
        k = 0;
        while (k < 3 * rob_cfg_pkg::rob_depth) begin
            try_dispatch(taken);
            if (taken) begin
                k++;
            end
            write_back_some(2);
        end
        while (count_pending() > 0) begin
            write_back_some(2);
        end
        wait_drain(20);
        end_test("streaming with wrap");

        // six in flight, branch at position 1..4
        for (int i = 0; i < 6; i++) begin
            try_dispatch(taken);
            check(taken, "dispatch refused into an empty buffer");
        end
        k      = 1 + (next_rand() % 4);
        br_idx = exp_q[k].idx;
        base   = commit_count;
        squash_at(k, exp_mask);
        drive_cycle(1'b0);
        check(free_valid_o, "no free pulse after the mispredict");
        check(free_mask_o == exp_mask,
              $sformatf("free mask %h, expected %h", free_mask_o, exp_mask));
        drive_cycle(1'b0);
        check(!free_valid_o, "free pulse longer than one cycle");
        try_dispatch(taken);
        check(taken && exp_q[exp_q.size() - 1].idx == br_idx + 1'b1,
              "allocation after mispredict not at branch plus one");
        end_test("mispredict and free mask");

        // survivors and the new ones commit, squashed ones never
        try_dispatch(taken);
        while (count_pending() > 0) begin
            write_back_some(2);
        end
        wait_drain(20);
        check(commit_count - base == k + 3,
              $sformatf("%0d commits after squash, expected %0d", commit_count - base, k + 3));
        end_test("commit after squash");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rob_top.sv */
//==========================================================================
// reorder buffer top; connects allocation, entry table, retire and squash
//==========================================================================
`default_nettype none
`timescale 1ns/1ns

module rob_top (
    input  wire                     clock,
    input  wire                     reset,

    // dispatch
    input  logic                    dispatch_valid_i,
    input  rob_msg_pkg::disp_req_t  dispatch_i,
    output logic                    dispatch_ready_o,
    output logic                    alloc_o,
    output rob_cfg_pkg::rob_idx_t   alloc_idx_o,

    // writeback
    input  rob_msg_pkg::wb_req_t    wb_i [rob_cfg_pkg::wb_ports],

    // branch recovery
    input  logic                    mispredict_i,
    input  rob_cfg_pkg::rob_idx_t   mispredict_idx_i,

    // commit
    output logic                    commit_valid_o,
    output rob_msg_pkg::commit_t    commit_o,

    // free list reclaim
    output logic                    free_valid_o,
    output rob_cfg_pkg::phys_mask_t free_mask_o
);

    // retire <-> table
    rob_cfg_pkg::rob_idx_t   head_idx;
    rob_msg_pkg::rob_entry_t head_entry;
    logic                    retire_fire;

    // table <-> squash
    rob_cfg_pkg::rob_mask_t  valid_mask;
    rob_cfg_pkg::phys_reg_t  old_prf [rob_cfg_pkg::rob_depth];
    rob_cfg_pkg::rob_mask_t  squash_mask;
    rob_cfg_pkg::rob_cnt_t   squash_count;

    rob_alloc alloc_inst (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .alloc_o          (alloc_o),
        .alloc_idx_o      (alloc_idx_o),
        .mispredict_i     (mispredict_i),
        .mispredict_idx_i (mispredict_idx_i),
        .squash_count_i   (squash_count),
        .retire_fire_i    (retire_fire)
    );

    // alloc_idx_o doubles as the tail for the table and the walk
    rob_entry_table table_inst (
        .clock         (clock),
        .reset         (reset),
        .alloc_i       (alloc_o),
        .alloc_idx_i   (alloc_idx_o),
        .dispatch_i    (dispatch_i),
        .wb_i          (wb_i),
        .head_idx_i    (head_idx),
        .retire_fire_i (retire_fire),
        .head_entry_o  (head_entry),
        .squash_mask_i (squash_mask),
        .valid_mask_o  (valid_mask),
        .old_prf_o     (old_prf)
    );

    rob_retire retire_inst (
        .clock          (clock),
        .reset          (reset),
        .head_entry_i   (head_entry),
        .mispredict_i   (mispredict_i),
        .head_idx_o     (head_idx),
        .retire_fire_o  (retire_fire),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    rob_squash squash_inst (
        .clock            (clock),
        .reset            (reset),
        .mispredict_i     (mispredict_i),
        .mispredict_idx_i (mispredict_idx_i),
        .tail_i           (alloc_idx_o),
        .valid_mask_i     (valid_mask),
        .old_prf_i        (old_prf),
        .squash_mask_o    (squash_mask),
        .squash_count_o   (squash_count),
        .free_valid_o     (free_valid_o),
        .free_mask_o      (free_mask_o)
    );

endmodule

`default_nettype wire

/* rob_squash.sv */
//==========================================================================
// squash stage: marks entries younger than a mispredicted branch and
// reports their old mappings to the free list one cycle later
//==========================================================================
`default_nettype none
`timescale 1ns/1ns

module rob_squash (
    input  wire                     clock,
    input  wire                     reset,

    // branch recovery request
    input  logic                    mispredict_i,
    input  rob_cfg_pkg::rob_idx_t   mispredict_idx_i,
    input  rob_cfg_pkg::rob_idx_t   tail_i,

    // table view
    input  rob_cfg_pkg::rob_mask_t  valid_mask_i,
    input  rob_cfg_pkg::phys_reg_t  old_prf_i [rob_cfg_pkg::rob_depth],

    // to table and allocation
    output rob_cfg_pkg::rob_mask_t  squash_mask_o,
    output rob_cfg_pkg::rob_cnt_t   squash_count_o,

    // to the free list
    output logic                    free_valid_o,
    output rob_cfg_pkg::phys_mask_t free_mask_o
);

    rob_cfg_pkg::phys_mask_t free_mask_d;

    //======================================================================
    // walk from branch+1 up to the tail
    //======================================================================

    always_comb begin
        rob_cfg_pkg::rob_idx_t idx;
        logic                  walking;

        squash_mask_o  = '0;
        squash_count_o = '0;
        free_mask_d    = '0;
        walking        = mispredict_i;

        for (int j = 1; j < rob_cfg_pkg::rob_depth; j++) begin
            idx = mispredict_idx_i + rob_cfg_pkg::rob_idx_t'(j);
            // tail is the first slot not holding a younger entry
            if (idx == tail_i) begin
                walking = 1'b0;
            end
            if (walking && valid_mask_i[idx]) begin
                squash_mask_o[idx] = 1'b1;
                squash_count_o     = squash_count_o + rob_cfg_pkg::rob_cnt_t'(1);
                // r0 mapping is never handed back
                if (old_prf_i[idx] != '0) begin
                    free_mask_d[old_prf_i[idx]] = 1'b1;
                end
            end
        end
    end

    //======================================================================
    // free pulse, the cycle after the mispredict
    //======================================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            free_valid_o <= 1'b0;
        end else begin
            free_valid_o <= mispredict_i;
        end
    end

    always_ff @(posedge clock) begin
        if (mispredict_i) begin
            free_mask_o <= free_mask_d;
        end
    end

endmodule

`default_nettype wire

/* rob_retire.sv */
//==========================================================================
// retire stage: head pointer, in-order retire and registered commit
//==========================================================================
`default_nettype none
`timescale 1ns/1ns

module rob_retire (
    input  wire                     clock,
    input  wire                     reset,

    // head entry from the table
    input  rob_msg_pkg::rob_entry_t head_entry_i,
    input  logic                    mispredict_i,

    output rob_cfg_pkg::rob_idx_t   head_idx_o,
    output logic                    retire_fire_o,

    // commit port, one instruction per cycle at most
    output logic                    commit_valid_o,
    output rob_msg_pkg::commit_t    commit_o
);

    rob_cfg_pkg::rob_idx_t head_q;

    // oldest entry goes once its writeback is in
    // held during a mispredict so the walk sees a stable head
    assign retire_fire_o = head_entry_i.valid && head_entry_i.ready && !mispredict_i;

    assign head_idx_o = head_q;

    //======================================================================
    // head and commit strobe
    //======================================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q         <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            // wraps with the index width
            if (retire_fire_o) begin
                head_q <= head_q + rob_cfg_pkg::rob_idx_t'(1);
            end
            // single cycle pulse per retirement
            commit_valid_o <= retire_fire_o;
        end
    end

    // commit record, only meaningful with commit_valid_o
    always_ff @(posedge clock) begin
        if (retire_fire_o) begin
            commit_o.rd_wen  <= head_entry_i.req.rd_wen;
            commit_o.rd_arch <= head_entry_i.req.rd_arch;
            commit_o.new_prf <= head_entry_i.req.new_prf;
            commit_o.old_prf <= head_entry_i.req.old_prf;
            commit_o.value   <= head_entry_i.value;
        end
    end

endmodule

`default_nettype wire

/* rob_entry_table.sv */
//==========================================================================
// entry storage; written by dispatch and writeback, cleared by retire
// and squash, read at the head and by the squash walk
//==========================================================================
`default_nettype none
`timescale 1ns/1ns

module rob_entry_table (
    input  wire                     clock,
    input  wire                     reset,

    // allocation
    input  logic                    alloc_i,
    input  rob_cfg_pkg::rob_idx_t   alloc_idx_i,
    input  rob_msg_pkg::disp_req_t  dispatch_i,

    // writeback ports
    input  rob_msg_pkg::wb_req_t    wb_i [rob_cfg_pkg::wb_ports],

    // retire
    input  rob_cfg_pkg::rob_idx_t   head_idx_i,
    input  logic                    retire_fire_i,
    output rob_msg_pkg::rob_entry_t head_entry_o,

    // squash
    input  rob_cfg_pkg::rob_mask_t  squash_mask_i,
    output rob_cfg_pkg::rob_mask_t  valid_mask_o,
    output rob_cfg_pkg::phys_reg_t  old_prf_o [rob_cfg_pkg::rob_depth]
);

    // per-entry state bits
    rob_cfg_pkg::rob_mask_t valid_q;
    rob_cfg_pkg::rob_mask_t valid_d;
    rob_cfg_pkg::rob_mask_t ready_q;
    rob_cfg_pkg::rob_mask_t ready_d;

    // payload arrays
    rob_msg_pkg::disp_req_t req_q   [rob_cfg_pkg::rob_depth];
    rob_cfg_pkg::xlen_t     value_q [rob_cfg_pkg::rob_depth];

    //======================================================================
    // valid and ready
    //======================================================================

    always_comb begin
        // squash clears whatever the walk marked
        valid_d = valid_q & ~squash_mask_i;
        ready_d = ready_q;

        // head leaves on retire
        if (retire_fire_i) begin
            valid_d[head_idx_i] = 1'b0;
        end

        // writeback marks done, also on a squashed entry
        for (int p = 0; p < rob_cfg_pkg::wb_ports; p++) begin
            if (wb_i[p].valid) begin
                ready_d[wb_i[p].rob_idx] = 1'b1;
            end
        end

        // fresh entry starts not done
        if (alloc_i) begin
            valid_d[alloc_idx_i] = 1'b1;
            ready_d[alloc_idx_i] = 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            valid_q <= valid_d;
            ready_q <= ready_d;
        end
    end

    //======================================================================
    // payload
    //======================================================================

    always_ff @(posedge clock) begin
        if (alloc_i) begin
            req_q[alloc_idx_i] <= dispatch_i;
        end
        // ports never share an index in one cycle
        for (int p = 0; p < rob_cfg_pkg::wb_ports; p++) begin
            if (wb_i[p].valid) begin
                value_q[wb_i[p].rob_idx] <= wb_i[p].value;
            end
        end
    end

    // head view for the retire stage
    always_comb begin
        head_entry_o.valid = valid_q[head_idx_i];
        head_entry_o.ready = ready_q[head_idx_i];
        head_entry_o.req   = req_q[head_idx_i];
        head_entry_o.value = value_q[head_idx_i];
    end

    // full view for the squash walk
    assign valid_mask_o = valid_q;

    always_comb begin
        for (int i = 0; i < rob_cfg_pkg::rob_depth; i++) begin
            old_prf_o[i] = req_q[i].old_prf;
        end
    end

endmodule

`default_nettype wire

/* rob_alloc.sv */
//==========================================================================
// allocation stage: tail pointer, occupancy and dispatch acceptance
//==========================================================================
`default_nettype none
`timescale 1ns/1ns

module rob_alloc (
    input  wire                   clock,
    input  wire                   reset,

    // dispatch side
    input  logic                  dispatch_valid_i,
    output logic                  dispatch_ready_o,
    output logic                  alloc_o,
    output rob_cfg_pkg::rob_idx_t alloc_idx_o,

    // branch recovery
    input  logic                  mispredict_i,
    input  rob_cfg_pkg::rob_idx_t mispredict_idx_i,
    input  rob_cfg_pkg::rob_cnt_t squash_count_i,

    // from retire
    input  logic                  retire_fire_i
);

    rob_cfg_pkg::rob_idx_t tail_q;
    rob_cfg_pkg::rob_cnt_t count_q;
    logic                  full;

    //======================================================================
    // acceptance
    //======================================================================

    // full when every entry holds an instruction
    assign full = (count_q == rob_cfg_pkg::rob_cnt_t'(rob_cfg_pkg::rob_depth));

    // no new work while the younger entries are being cleared
    assign dispatch_ready_o = !full && !mispredict_i;
    assign alloc_o          = dispatch_valid_i && dispatch_ready_o;

    // new instruction lands at the tail
    assign alloc_idx_o = tail_q;

    //======================================================================
    // tail and count
    //======================================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tail_q  <= '0;
            count_q <= '0;
        end else if (mispredict_i) begin
            // branch keeps its entry, tail restarts right after it
            tail_q  <= mispredict_idx_i + rob_cfg_pkg::rob_idx_t'(1);
            // retire and alloc are both held off this cycle
            count_q <= count_q - squash_count_i;
        end else begin
            // tail wraps with the index width
            if (alloc_o) begin
                tail_q <= tail_q + rob_cfg_pkg::rob_idx_t'(1);
            end
            // one in, one out, or both
            count_q <= count_q
                     + rob_cfg_pkg::rob_cnt_t'(alloc_o)
                     - rob_cfg_pkg::rob_cnt_t'(retire_fire_i);
        end
    end

endmodule

`default_nettype wire

/* rob_msg_pkg.sv */
//==========================================================================
// packed records passed between reorder buffer stages and to the ports
//==========================================================================
`default_nettype none

package rob_msg_pkg;

    // one dispatched instruction, 18 bits
    typedef struct packed {
        logic                  rd_wen;
        rob_cfg_pkg::arch_reg_t rd_arch;
        // mapping given by rename
        rob_cfg_pkg::phys_reg_t new_prf;
        // mapping it replaces, freed at commit or squash
        rob_cfg_pkg::phys_reg_t old_prf;
    } disp_req_t;

    // one writeback port, 36 bits
    typedef struct packed {
        logic                  valid;
        rob_cfg_pkg::rob_idx_t rob_idx;
        rob_cfg_pkg::xlen_t    value;
    } wb_req_t;

    // one retiring instruction, 50 bits
    typedef struct packed {
        logic                   rd_wen;
        rob_cfg_pkg::arch_reg_t rd_arch;
        rob_cfg_pkg::phys_reg_t new_prf;
        rob_cfg_pkg::phys_reg_t old_prf;
        rob_cfg_pkg::xlen_t     value;
    } commit_t;

    // one stored entry, 52 bits
    typedef struct packed {
        // entry in flight
        logic               valid;
        // writeback seen
        logic               ready;
        disp_req_t          req;
        rob_cfg_pkg::xlen_t value;
    } rob_entry_t;

endpackage

`default_nettype wire

/* rob_cfg_pkg.sv */
//==========================================================================
// reorder buffer sizing and the plain vector types built on it
//==========================================================================
`default_nettype none

package rob_cfg_pkg;

    // buffer and register file sizing
    localparam int unsigned rob_depth = 8;
    localparam int unsigned arch_regs = 32;
    localparam int unsigned phys_regs = 64;
    localparam int unsigned xlen      = 32;
    localparam int unsigned wb_ports  = 2;

    // derived widths
    localparam int unsigned rob_idx_w  = $clog2(rob_depth);
    localparam int unsigned rob_cnt_w  = $clog2(rob_depth + 1);
    localparam int unsigned arch_reg_w = $clog2(arch_regs);
    localparam int unsigned phys_reg_w = $clog2(phys_regs);

    // index and count; count has to reach rob_depth itself
    typedef logic [rob_idx_w-1:0]  rob_idx_t;
    typedef logic [rob_cnt_w-1:0]  rob_cnt_t;

    // register numbers and data
    typedef logic [arch_reg_w-1:0] arch_reg_t;
    typedef logic [phys_reg_w-1:0] phys_reg_t;
    typedef logic [xlen-1:0]       xlen_t;

    // one bit per entry / per physical register
    typedef logic [rob_depth-1:0]  rob_mask_t;
    typedef logic [phys_regs-1:0]  phys_mask_t;

endpackage

`default_nettype wire
